//--- Bender.yml
package:
  name: cci_shim

sources:
  - files:
      - cci_pkg.sv
      - tag_free_list.sv
      - meta_ram.sv
      - qlp_rx_buffer.sv
      - tag_meta_shim.sv
      - cci_shim_top.sv
  - target: test
    files:
      - tb_cci_shim_checker.sv
      - tb_cci_shim.sv

//--- cci_pkg.sv
// Shared widths, tag space and packed request/response types for the read-path
// tagging shim. Import it wherever these types or constants are needed.

package cci_pkg;

    // The host link tracks at most this many reads in flight
    localparam int NUM_TAGS = 16;
    localparam int TAG_W = $clog2(NUM_TAGS);

    // Free-tag counter must hold the full value NUM_TAGS, so it needs one extra bit
    localparam int CNT_W = $clog2(NUM_TAGS + 1);

    // The AFU is throttled once the free list drains to this many tags
    localparam int ALM_EMPTY_LEVEL = 2;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int MDATA_W = 8;

    // Cache line address as seen by both sides
    typedef logic [ADDR_W-1:0] addr_t;
    // Read response payload
    typedef logic [DATA_W-1:0] data_t;
    // Host-side tag, owned by the shim
    typedef logic [TAG_W-1:0] tag_t;
    // AFU-side metadata, opaque to the shim and returned unchanged
    typedef logic [MDATA_W-1:0] mdata_t;
    // Number of tags currently in the free list
    typedef logic [CNT_W-1:0] tag_cnt_t;

    // Read request as issued by the AFU
    typedef struct packed {
        addr_t  addr;
        mdata_t mdata;
    } afu_rd_req_t;

    // Read request as it leaves toward the host, metadata swapped for a tag
    typedef struct packed {
        addr_t addr;
        tag_t  tag;
    } host_rd_req_t;

    // Read response from the host, keyed by tag
    typedef struct packed {
        tag_t  tag;
        data_t data;
    } host_rd_rsp_t;

    // Read response handed back to the AFU with its own metadata restored
    typedef struct packed {
        mdata_t mdata;
        data_t  data;
    } afu_rd_rsp_t;

endpackage

//--- cci_shim_top.sv
// Read-path shim between an AFU and the host link. Requests are retagged on the
// way out and responses get their AFU metadata back one cycle after arrival.

module cci_shim_top
#(
    // Passed to the buffer, adds a cycle to the request path when nonzero
    parameter int REGISTER_OUTBOUND = 0
)
(
    input  logic                  clk,
    input  logic                  rst_n,

    // AFU side
    input  logic                  afu_rd_valid,
    input  cci_pkg::afu_rd_req_t  afu_rd_req,
    output logic                  afu_almost_full,
    output logic                  afu_rsp_valid,
    output cci_pkg::afu_rd_rsp_t  afu_rsp,

    // Host side
    output logic                  host_rd_valid,
    output cci_pkg::host_rd_req_t host_rd_req,
    input  logic                  host_almost_full,
    input  logic                  host_rsp_valid,
    input  cci_pkg::host_rd_rsp_t host_rsp
);
    import cci_pkg::*;

    // Buffered connection between the tagging shim and the buffer
    logic         buf_rd_valid;
    host_rd_req_t buf_rd_req;
    logic         buf_almost_full;
    logic         buf_rsp_valid;
    host_rd_rsp_t buf_rsp;

    tag_meta_shim tag_shim_i
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .afu_rd_valid    (afu_rd_valid),
        .afu_rd_req      (afu_rd_req),
        .afu_almost_full (afu_almost_full),
        .afu_rsp_valid   (afu_rsp_valid),
        .afu_rsp         (afu_rsp),
        .qlp_rd_valid    (buf_rd_valid),
        .qlp_rd_req      (buf_rd_req),
        .qlp_almost_full (buf_almost_full),
        // Raw tag starts the metadata lookup before the buffer releases the response
        .raw_rsp_tag     (host_rsp.tag),
        .qlp_rsp_valid   (buf_rsp_valid),
        .qlp_rsp         (buf_rsp)
    );

    qlp_rx_buffer #(
        .REGISTER_OUTBOUND (REGISTER_OUTBOUND)
    ) rx_buffer_i
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .buf_rd_valid    (buf_rd_valid),
        .buf_rd_req      (buf_rd_req),
        .buf_almost_full (buf_almost_full),
        .buf_rsp_valid   (buf_rsp_valid),
        .buf_rsp         (buf_rsp),
        .raw_rd_valid    (host_rd_valid),
        .raw_rd_req      (host_rd_req),
        .raw_almost_full (host_almost_full),
        .raw_rsp_valid   (host_rsp_valid),
        .raw_rsp         (host_rsp)
    );

endmodule

//--- meta_ram.sv
// Per-tag store for AFU metadata. Simple dual-port, one write and one read,
// with a one-cycle registered read so it maps onto block RAM.

module meta_ram
(
    input  logic           clk,

    // Written when a request is tagged
    input  logic           wr_en,
    input  cci_pkg::tag_t  wr_addr,
    input  cci_pkg::mdata_t wr_data,

    // Read address is the raw response tag, data follows one cycle later
    input  cci_pkg::tag_t  rd_addr,
    output cci_pkg::mdata_t rd_data
);
    import cci_pkg::*;

    mdata_t mem [NUM_TAGS];

    // Contents are only meaningful for tags that are in flight
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read every cycle, the consumer decides whether the result is used
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- qlp_rx_buffer.sv
// Interposer on the host side of the shim. Every response gets one register stage,
// giving a block RAM lookup started on the raw tag time to complete.

module qlp_rx_buffer
#(
    // Nonzero registers the outbound request and the inbound almost-full
    parameter int REGISTER_OUTBOUND = 0
)
(
    input  logic                  clk,
    input  logic                  rst_n,

    // Buffered side, faces the tagging shim
    input  logic                  buf_rd_valid,
    input  cci_pkg::host_rd_req_t buf_rd_req,
    output logic                  buf_almost_full,
    output logic                  buf_rsp_valid,
    output cci_pkg::host_rd_rsp_t buf_rsp,

    // Raw side, faces the host link
    output logic                  raw_rd_valid,
    output cci_pkg::host_rd_req_t raw_rd_req,
    input  logic                  raw_almost_full,
    input  logic                  raw_rsp_valid,
    input  cci_pkg::host_rd_rsp_t raw_rsp
);
    import cci_pkg::*;

    // Request direction, wires or a single register stage
    generate
        if (REGISTER_OUTBOUND == 0)
        begin : g_tx_pass
            assign raw_rd_valid    = buf_rd_valid;
            assign raw_rd_req      = buf_rd_req;
            assign buf_almost_full = raw_almost_full;
        end
        else
        begin : g_tx_reg
            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    raw_rd_valid    <= 1'b0;
                    buf_almost_full <= 1'b0;
                end
                else
                begin
                    raw_rd_valid    <= buf_rd_valid;
                    buf_almost_full <= raw_almost_full;
                end
            end

            // Request payload is qualified by the valid
            always_ff @(posedge clk)
            begin
                raw_rd_req <= buf_rd_req;
            end
        end
    endgenerate

    // Responses are always delayed by one cycle, and there is no back-pressure
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            buf_rsp_valid <= 1'b0;
        end
        else
        begin
            buf_rsp_valid <= raw_rsp_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        buf_rsp <= raw_rsp;
    end

endmodule

//--- sim.f
cci_pkg.sv
tag_free_list.sv
meta_ram.sv
qlp_rx_buffer.sv
tag_meta_shim.sv
cci_shim_top.sv
tb_cci_shim_checker.sv
tb_cci_shim.sv

//--- tag_free_list.sv
// Circular FIFO of unused host tags, filled with every tag at reset.
// The head tag is offered on alloc_tag; alloc pops it and free pushes a returned tag.

module tag_free_list
(
    input  logic          clk,
    input  logic          rst_n,

    // Pop side, the head is valid whenever the list is not empty
    input  logic          alloc,
    output cci_pkg::tag_t alloc_tag,

    // Push side for tags coming back with their responses
    input  logic          free,
    input  cci_pkg::tag_t free_tag,

    output logic          almost_empty
);
    import cci_pkg::*;

    // Storage has exactly one slot per tag, so it can never overflow
    tag_t     tags [NUM_TAGS];
    tag_t     rd_ptr;
    tag_t     wr_ptr;
    tag_cnt_t count;

    assign alloc_tag = tags[rd_ptr];

    // Pointers are tag-wide, so they wrap on their own at NUM_TAGS
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // Start out holding tags 0 to NUM_TAGS-1 in order
            for (int i = 0; i < NUM_TAGS; i++)
            begin
                tags[i] <= tag_t'(i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
        end
        else
        begin
            if (alloc)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (free)
            begin
                tags[wr_ptr] <= free_tag;
                wr_ptr       <= wr_ptr + 1'b1;
            end
        end
    end

    // Occupancy, a simultaneous pop and push leaves it unchanged
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= tag_cnt_t'(NUM_TAGS);
        end
        else
        begin
            case ({alloc, free})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Early warning so requests already on their way still find a tag
    assign almost_empty = (count <= tag_cnt_t'(ALM_EMPTY_LEVEL));

endmodule

//--- tag_meta_shim.sv
// Swaps AFU metadata for a host tag on each read, and swaps it back on the
// response. Sits on the buffered side of qlp_rx_buffer and also sees the raw tag.

module tag_meta_shim
(
    input  logic                  clk,
    input  logic                  rst_n,

    // AFU side
    input  logic                  afu_rd_valid,
    input  cci_pkg::afu_rd_req_t  afu_rd_req,
    output logic                  afu_almost_full,
    output logic                  afu_rsp_valid,
    output cci_pkg::afu_rd_rsp_t  afu_rsp,

    // Buffered host side
    output logic                  qlp_rd_valid,
    output cci_pkg::host_rd_req_t qlp_rd_req,
    input  logic                  qlp_almost_full,

    // Tag of the unbuffered response, one cycle ahead of qlp_rsp
    input  cci_pkg::tag_t         raw_rsp_tag,
    input  logic                  qlp_rsp_valid,
    input  cci_pkg::host_rd_rsp_t qlp_rsp
);
    import cci_pkg::*;

    tag_t   alloc_tag;
    logic   tags_low;
    mdata_t rsp_mdata;

    // Free list of host tags
    //
    // A request takes the head tag in the cycle it arrives. The tag of a
    // buffered response goes back in the same cycle that response leaves.
    tag_free_list free_list_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (afu_rd_valid),
        .alloc_tag    (alloc_tag),
        .free         (qlp_rsp_valid),
        .free_tag     (qlp_rsp.tag),
        .almost_empty (tags_low)
    );

    // Metadata store indexed by tag
    //
    // The write happens alongside the outgoing request. The read is launched
    // by the raw response tag so the data lines up with the buffered response.
    meta_ram meta_ram_i
    (
        .clk     (clk),
        .wr_en   (afu_rd_valid),
        .wr_addr (alloc_tag),
        .wr_data (afu_rd_req.mdata),
        .rd_addr (raw_rsp_tag),
        .rd_data (rsp_mdata)
    );

    // Outbound requests keep their address and carry the allocated tag
    // instead of the AFU metadata. No extra latency is added here.
    always_comb
    begin
        qlp_rd_valid    = afu_rd_valid;
        qlp_rd_req.addr = afu_rd_req.addr;
        qlp_rd_req.tag  = alloc_tag;
    end

    // Throttle the AFU when the host is backing up or tags are running out.
    // The free-list level leaves room for requests issued before the
    // registered almost-full from the buffer has caught up.
    assign afu_almost_full = qlp_almost_full | tags_low;

    // Responses leave in the same cycle they come out of the buffer,
    // with the RAM output supplying the original metadata
    always_comb
    begin
        afu_rsp_valid = qlp_rsp_valid;
        afu_rsp.mdata = rsp_mdata;
        afu_rsp.data  = qlp_rsp.data;
    end

endmodule

//--- tb_cci_shim.sv
// Testbench for cci_shim_top. An LFSR-driven AFU and host model run a reset, a
// throttling and a random traffic test while the bound checker watches the DUT.

module tb_cci_shim
#(
    parameter int REGISTER_OUTBOUND = 0
);
    timeunit 1ns;
    timeprecision 100ps;
    import cci_pkg::*;

    localparam int THROTTLE_REQS = 14;
    localparam int RAND_REQS = 150;
    localparam int CYCLE_LIMIT = 4 * (THROTTLE_REQS + RAND_REQS) + 200;

    logic         clk;
    logic         rst_n;
    logic         afu_rd_valid;
    afu_rd_req_t  afu_rd_req;
    logic         afu_almost_full;
    logic         afu_rsp_valid;
    afu_rd_rsp_t  afu_rsp;
    logic         host_rd_valid;
    host_rd_req_t host_rd_req;
    logic         host_almost_full;
    logic         host_rsp_valid;
    host_rd_rsp_t host_rsp;

    // Traffic controls, written by the test sequence on rising edges
    int   afu_todo;
    logic afu_b2b;
    logic rsp_en;
    logic af_rand_en;

    // State of the AFU and host models
    logic [31:0]  lfsr = 32'h2b171a72;
    logic         md_busy [256];
    mdata_t       next_md;
    host_rd_req_t host_q [$];
    int           req_count;
    int           rsp_count;
    int           host_rx_count;
    int           tb_errors;
    int           tests_failed;
    int           cycles;

    cci_shim_top #(.REGISTER_OUTBOUND(REGISTER_OUTBOUND)) dut_i
    (
        .clk              (clk),
        .rst_n            (rst_n),
        .afu_rd_valid     (afu_rd_valid),
        .afu_rd_req       (afu_rd_req),
        .afu_almost_full  (afu_almost_full),
        .afu_rsp_valid    (afu_rsp_valid),
        .afu_rsp          (afu_rsp),
        .host_rd_valid    (host_rd_valid),
        .host_rd_req      (host_rd_req),
        .host_almost_full (host_almost_full),
        .host_rsp_valid   (host_rsp_valid),
        .host_rsp         (host_rsp)
    );

    always #4 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit returned
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic int err_total();
        return tb_errors + dut_i.checker_i.err_cnt;
    endfunction

    task automatic report_test(input string name, input int errs_start);
        int errs;
        errs = err_total() - errs_start;
        if (errs != 0)
        begin
            tests_failed++;
        end
        $display("test %-8s finished with %0d errors", name, errs);
    endtask

    // Waits until every planned request has been issued and answered
    task automatic wait_drain();
        @(negedge clk);
        while (afu_todo != 0 || rsp_count != req_count)
        begin
            @(negedge clk);
        end
    endtask

    // AFU and host models share one process, so the LFSR order is fixed
    always @(posedge clk)
    begin
        host_rd_req_t req;
        int           idx;
        if (rst_n)
        begin
            // Metadata becomes reusable once its response is seen
            if (afu_rsp_valid)
            begin
                md_busy[afu_rsp.mdata] = 1'b0;
                rsp_count++;
            end
            if (afu_todo > 0 && !afu_almost_full && (afu_b2b || rand_bits(2) != 0))
            begin
                while (md_busy[next_md])
                begin
                    next_md++;
                end
                md_busy[next_md] = 1'b1;
                afu_rd_valid <= 1'b1;
                afu_rd_req   <= '{addr: rand_bits(32), mdata: next_md};
                next_md++;
                afu_todo--;
                req_count++;
            end
            else
            begin
                afu_rd_valid <= 1'b0;
            end
            if (host_rd_valid)
            begin
                host_q.push_back(host_rd_req);
                host_rx_count++;
            end
            // Host answers a random outstanding read most cycles
            if (rsp_en && host_q.size() > 0 && rand_bits(2) != 0)
            begin
                idx = rand_bits(4) % host_q.size();
                req = host_q[idx];
                host_q.delete(idx);
                host_rsp_valid <= 1'b1;
                host_rsp       <= '{tag: req.tag,
                                    data: data_t'(req.addr) ^ 64'h5a5a_0000_a5a5_0000};
            end
            else
            begin
                host_rsp_valid <= 1'b0;
            end
            if (!af_rand_en)
            begin
                host_almost_full <= 1'b0;
            end
            else if (host_almost_full ? rand_bits(1) != 0 : rand_bits(3) == 0)
            begin
                host_almost_full <= !host_almost_full;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Run stopped, DUT traffic did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial
    begin
        int errs_start;
        clk = 1'b0;
        rst_n = 1'b0;
        // Both incoming valids are high during reset, the registered paths must not pass them
        afu_rd_valid = 1'b1;
        afu_rd_req = '0;
        host_almost_full = 1'b0;
        host_rsp_valid = 1'b1;
        host_rsp = '0;
        afu_todo = 0;
        afu_b2b = 1'b0;
        rsp_en = 1'b0;
        af_rand_en = 1'b0;
        md_busy = '{default: 1'b0};
        next_md = '0;
        req_count = 0;
        rsp_count = 0;
        host_rx_count = 0;
        tb_errors = 0;
        tests_failed = 0;
        cycles = 0;
        repeat (3) @(posedge clk);
        rst_n          <= 1'b1;
        afu_rd_valid   <= 1'b0;
        host_rsp_valid <= 1'b0;
        // The checker looks at the valids on the first edge out of reset
        @(posedge clk);
        @(negedge clk);
        report_test("reset", 0);

        // Back-to-back requests with the host silent drain the free list
        errs_start = err_total();
        @(posedge clk);
        afu_b2b  <= 1'b1;
        afu_todo <= THROTTLE_REQS;
        @(negedge clk);
        while (afu_todo != 0)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk);
        assert (afu_almost_full)
        else
        begin
            $display("FAIL throttle: afu_almost_full expected 1, actual %0b", afu_almost_full);
            tb_errors++;
        end
        @(posedge clk);
        rsp_en <= 1'b1;
        wait_drain();
        assert (!afu_almost_full)
        else
        begin
            $display("FAIL throttle: afu_almost_full expected 0, actual %0b", afu_almost_full);
            tb_errors++;
        end
        assert (host_rx_count == THROTTLE_REQS)
        else
        begin
            $display("FAIL throttle: host requests expected %0d, actual %0d",
                THROTTLE_REQS, host_rx_count);
            tb_errors++;
        end
        report_test("throttle", errs_start);

        // Random gaps, response order and host almost-full
        errs_start = err_total();
        @(posedge clk);
        afu_b2b    <= 1'b0;
        af_rand_en <= 1'b1;
        afu_todo   <= RAND_REQS;
        wait_drain();
        @(posedge clk);
        af_rand_en <= 1'b0;
        assert (host_rx_count == THROTTLE_REQS + RAND_REQS)
        else
        begin
            $display("FAIL random: host requests expected %0d, actual %0d",
                THROTTLE_REQS + RAND_REQS, host_rx_count);
            tb_errors++;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        report_test("random", errs_start);

        $display("3 tests run, %0d failed, %0d errors in total", tests_failed, err_total());
        if (err_total() == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tb_cci_shim_checker.sv
// Assertion module bound into cci_shim_top. It follows outstanding reads by
// AFU metadata and by host tag, and checks payloads, tag reuse and latency.

module tb_cci_shim_checker
#(
    parameter int REGISTER_OUTBOUND = 0
)
(
    input logic                  clk,
    input logic                  rst_n,
    input logic                  afu_rd_valid,
    input cci_pkg::afu_rd_req_t  afu_rd_req,
    input logic                  afu_rsp_valid,
    input cci_pkg::afu_rd_rsp_t  afu_rsp,
    input logic                  host_rd_valid,
    input cci_pkg::host_rd_req_t host_rd_req,
    input logic                  host_rsp_valid,
    input cci_pkg::host_rd_rsp_t host_rsp
);
    timeunit 1ns;
    timeprecision 100ps;
    import cci_pkg::*;

    // Address of each outstanding read, keyed by its AFU metadata
    addr_t addr_of_md [256];
    logic  md_open [256];
    // Tags currently held by the host
    logic  tag_open [NUM_TAGS];
    // AFU request delayed by one cycle, for the registered request path
    logic  lat_valid;
    addr_t lat_addr;
    logic  exp_valid;
    addr_t exp_addr;
    int    err_cnt = 0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            md_open   <= '{default: 1'b0};
            tag_open  <= '{default: 1'b0};
            lat_valid <= 1'b0;
        end
        else
        begin
            if (afu_rd_valid)
            begin
                addr_of_md[afu_rd_req.mdata] <= afu_rd_req.addr;
                md_open[afu_rd_req.mdata]    <= 1'b1;
            end
            if (afu_rsp_valid)
            begin
                md_open[afu_rsp.mdata] <= 1'b0;
            end
            if (host_rd_valid)
            begin
                tag_open[host_rd_req.tag] <= 1'b1;
            end
            if (host_rsp_valid)
            begin
                tag_open[host_rsp.tag] <= 1'b0;
            end
            lat_valid <= afu_rd_valid;
            lat_addr  <= afu_rd_req.addr;
        end
    end

    // What the host side should show this cycle
    assign exp_valid = (REGISTER_OUTBOUND != 0) ? lat_valid : afu_rd_valid;
    assign exp_addr  = (REGISTER_OUTBOUND != 0) ? lat_addr : afu_rd_req.addr;

    // Response data is the request address, zero-extended, XOR a fixed pattern
    a_rsp_payload: assert property (@(posedge clk) disable iff (!rst_n)
        afu_rsp_valid |-> md_open[afu_rsp.mdata] && afu_rsp.data ==
            (data_t'(addr_of_md[afu_rsp.mdata]) ^ 64'h5a5a_0000_a5a5_0000))
    else
    begin
        $error("FAIL rsp_payload: mdata %h expected data %h, actual %h",
            $sampled(afu_rsp.mdata),
            data_t'($sampled(addr_of_md[afu_rsp.mdata])) ^ 64'h5a5a_0000_a5a5_0000,
            $sampled(afu_rsp.data));
        err_cnt++;
    end

    a_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        host_rsp_valid |=> afu_rsp_valid)
    else
    begin
        $error("Host response was not passed to the AFU in the next cycle");
        err_cnt++;
    end

    a_req_latency: assert property (@(posedge clk) disable iff (!rst_n)
        host_rd_valid == exp_valid && (!exp_valid || host_rd_req.addr == exp_addr))
    else
    begin
        $error("FAIL req_latency: expected valid %0b addr %h, actual valid %0b addr %h",
            $sampled(exp_valid), $sampled(exp_addr),
            $sampled(host_rd_valid), $sampled(host_rd_req.addr));
        err_cnt++;
    end

    a_tag_unique: assert property (@(posedge clk) disable iff (!rst_n)
        host_rd_valid |-> !tag_open[host_rd_req.tag])
    else
    begin
        $error("Tag %0d was sent to the host while still outstanding", $sampled(host_rd_req.tag));
        err_cnt++;
    end

    // Registered valids must come out of reset low, whatever the inputs did during reset
    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !host_rd_valid && !afu_rsp_valid)
    else
    begin
        $error("A valid output was high in the first cycle after reset");
        err_cnt++;
    end

endmodule

bind cci_shim_top tb_cci_shim_checker #(.REGISTER_OUTBOUND(REGISTER_OUTBOUND)) checker_i (.*);
